// ==== verilog/stream_pkg.sv ====
package stream_pkg;

	// word and address widths.
	localparam int FEAT_W = 16;
	localparam int ADDR_W = 10;

	typedef logic signed [FEAT_W-1:0] feat_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// bank size and the fixed row walk.
	localparam int DEPTH = 1024;
	localparam int LINE_LEN = 4;
	localparam int ROW_STRIDE = 8;
	localparam int NUM_ROWS = 16;

	// counter widths for the walk.
	localparam int OFF_W = $clog2(LINE_LEN);
	localparam int ROW_W = $clog2(NUM_ROWS);

	// cycles from a read address to its data.
	localparam int RD_LATENCY = 3;

	// saturation limits of one feature word.
	localparam feat_t FEAT_MAX = feat_t'(16'sh7fff);
	localparam feat_t FEAT_MIN = feat_t'(16'sh8000);

	typedef enum logic {SCAN_IDLE, SCAN_RUN} scan_state_t;

endpackage

// ==== verilog/feature_ram.sv ====
`timescale 1ns/1ps

module feature_ram (
	input logic clk,
	input logic i_wen,
	input stream_pkg::addr_t i_waddr,
	input stream_pkg::feat_t i_wdata,
	input stream_pkg::addr_t i_raddr,
	output stream_pkg::feat_t o_rdata
);

	stream_pkg::feat_t mem [0:stream_pkg::DEPTH-1];

	stream_pkg::addr_t raddr_reg;
	stream_pkg::feat_t rdata_reg;
	stream_pkg::feat_t rdata_pipe;

	// write port.
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read path: address register, array register, output stage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		raddr_reg <= i_raddr;
	end

	// a write on an earlier cycle has landed before the array is read here.
	always_ff @(posedge clk) begin
		rdata_reg <= mem[raddr_reg];
	end

	always_ff @(posedge clk) begin
		rdata_pipe <= rdata_reg;
	end

	assign o_rdata = rdata_pipe;

endmodule

// ==== verilog/scan_address_gen.sv ====
`timescale 1ns/1ps

module scan_address_gen (
	input logic clk,
	input logic i_reset,
	input logic i_start,
	output stream_pkg::addr_t o_raddr,
	output logic o_active,
	output logic o_scan_last
);

	stream_pkg::scan_state_t state;

	logic [stream_pkg::OFF_W-1:0] off_cnt;
	logic [stream_pkg::ROW_W-1:0] row_cnt;
	logic [31:0] scan_addr_full;
	logic off_wrap;
	logic row_wrap;

	assign off_wrap = (off_cnt == stream_pkg::OFF_W'(stream_pkg::LINE_LEN - 1));
	assign row_wrap = (row_cnt == stream_pkg::ROW_W'(stream_pkg::NUM_ROWS - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// walk state machine.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= stream_pkg::SCAN_IDLE;
			off_cnt <= '0;
			row_cnt <= '0;
		end else begin
			case (state)
				stream_pkg::SCAN_IDLE: begin
					// a start is only taken here, never while running.
					if (i_start) begin
						state <= stream_pkg::SCAN_RUN;
						off_cnt <= '0;
						row_cnt <= '0;
					end
				end
				stream_pkg::SCAN_RUN: begin
					if (off_wrap) begin
						off_cnt <= '0;
						if (row_wrap) begin
							row_cnt <= '0;
							state <= stream_pkg::SCAN_IDLE;
						end else begin
							row_cnt <= row_cnt + 1'b1;
						end
					end else begin
						off_cnt <= off_cnt + 1'b1;
					end
				end
				default: state <= stream_pkg::SCAN_IDLE;
			endcase
		end
	end

	// row base plus offset, formed wide so the range check sees any overflow.
	assign scan_addr_full = 32'(row_cnt) * stream_pkg::ROW_STRIDE + 32'(off_cnt);

	assign o_raddr = stream_pkg::addr_t'(scan_addr_full);
	assign o_active = (state == stream_pkg::SCAN_RUN);
	assign o_scan_last = o_active && off_wrap && row_wrap;

	a_raddr_in_range: assert property (@(posedge clk) disable iff (i_reset)
		o_active |-> (scan_addr_full < stream_pkg::DEPTH));

endmodule

// ==== verilog/stream_buffer.sv ====
`timescale 1ns/1ps

module stream_buffer (
	input logic clk,
	input logic i_reset,
	input logic i_start,
	input logic i_wen0,
	input logic i_wen1,
	input stream_pkg::feat_t i_ddr,
	input stream_pkg::feat_t i_pool,
	input stream_pkg::feat_t i_eltwise,
	input logic i_eltwise_sel,
	input stream_pkg::addr_t i_waddr,
	output stream_pkg::feat_t o_feature_0,
	output stream_pkg::feat_t o_feature_1,
	output logic o_valid,
	output logic o_done
);

	stream_pkg::addr_t scan_raddr;
	logic scan_active;
	logic scan_last;
	stream_pkg::feat_t bank1_wdata;

	logic [stream_pkg::RD_LATENCY-1:0] active_pipe;
	logic [stream_pkg::RD_LATENCY-1:0] last_pipe;

	// one walk drives the read ports of both banks.
	scan_address_gen u_scan_address_gen (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.o_raddr(scan_raddr),
		.o_active(scan_active),
		.o_scan_last(scan_last)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// feature banks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	feature_ram u_bank0 (
		.clk(clk),
		.i_wen(i_wen0),
		.i_waddr(i_waddr),
		.i_wdata(i_ddr),
		.i_raddr(scan_raddr),
		.o_rdata(o_feature_0)
	);

	// bank 1 is filled by either the element-wise or the pooling path.
	always_comb begin
		if (i_eltwise_sel) begin
			bank1_wdata = i_eltwise;
		end else begin
			bank1_wdata = i_pool;
		end
	end

	feature_ram u_bank1 (
		.clk(clk),
		.i_wen(i_wen1),
		.i_waddr(i_waddr),
		.i_wdata(bank1_wdata),
		.i_raddr(scan_raddr),
		.o_rdata(o_feature_1)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// flag alignment to the bank read latency.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (i_reset) begin
			active_pipe <= '0;
			last_pipe <= '0;
		end else begin
			active_pipe <= {active_pipe[stream_pkg::RD_LATENCY-2:0], scan_active};
			last_pipe <= {last_pipe[stream_pkg::RD_LATENCY-2:0], scan_last};
		end
	end

	assign o_valid = active_pipe[stream_pkg::RD_LATENCY-1];
	assign o_done = last_pipe[stream_pkg::RD_LATENCY-1];

	a_done_has_valid: assert property (@(posedge clk) disable iff (i_reset)
		o_done |-> o_valid);

endmodule

// ==== verilog/residual_adder.sv ====
`timescale 1ns/1ps

module residual_adder (
	input logic clk,
	input logic i_reset,
	input stream_pkg::feat_t i_a,
	input stream_pkg::feat_t i_b,
	input logic i_valid,
	input logic i_last,
	output stream_pkg::feat_t o_sum,
	output logic o_sum_valid,
	output logic o_sum_last
);

	logic signed [stream_pkg::FEAT_W:0] sum_full;
	stream_pkg::feat_t sum_sat;

	// one extra bit holds any sum of two words.
	assign sum_full = (stream_pkg::FEAT_W + 1)'(i_a) + (stream_pkg::FEAT_W + 1)'(i_b);

	always_comb begin
		if (sum_full > stream_pkg::FEAT_MAX) begin
			sum_sat = stream_pkg::FEAT_MAX;
		end else if (sum_full < stream_pkg::FEAT_MIN) begin
			sum_sat = stream_pkg::FEAT_MIN;
		end else begin
			sum_sat = stream_pkg::feat_t'(sum_full);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		o_sum <= sum_sat;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_sum_valid <= 1'b0;
			o_sum_last <= 1'b0;
		end else begin
			o_sum_valid <= i_valid;
			o_sum_last <= i_last;
		end
	end

	a_last_has_valid: assert property (@(posedge clk) disable iff (i_reset)
		o_sum_last |-> o_sum_valid);

endmodule

// ==== verilog/feature_stream_top.sv ====
`timescale 1ns/1ps

module feature_stream_top (
	input logic clk,
	input logic i_reset,
	input logic i_start,
	input logic i_wen0,
	input logic i_wen1,
	input stream_pkg::feat_t i_ddr,
	input stream_pkg::feat_t i_pool,
	input stream_pkg::feat_t i_eltwise,
	input logic i_eltwise_sel,
	input stream_pkg::addr_t i_waddr,
	output stream_pkg::feat_t o_sum,
	output logic o_sum_valid,
	output logic o_sum_last
);

	stream_pkg::feat_t feature_0;
	stream_pkg::feat_t feature_1;
	logic feature_valid;
	logic feature_done;

	stream_buffer u_stream_buffer (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.i_wen0(i_wen0),
		.i_wen1(i_wen1),
		.i_ddr(i_ddr),
		.i_pool(i_pool),
		.i_eltwise(i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.i_waddr(i_waddr),
		.o_feature_0(feature_0),
		.o_feature_1(feature_1),
		.o_valid(feature_valid),
		.o_done(feature_done)
	);

	// the adder always accepts, so the pair stream feeds it directly.
	residual_adder u_residual_adder (
		.clk(clk),
		.i_reset(i_reset),
		.i_a(feature_0),
		.i_b(feature_1),
		.i_valid(feature_valid),
		.i_last(feature_done),
		.o_sum(o_sum),
		.o_sum_valid(o_sum_valid),
		.o_sum_last(o_sum_last)
	);

endmodule

// ==== tests/tb_feature_stream.sv ====
`timescale 1ns/1ps

module tb_feature_stream;

	localparam int NUM_TESTS = 5;
	localparam int LOAD_CYCLES = 128;
	localparam int WALK_LEN = stream_pkg::LINE_LEN * stream_pkg::NUM_ROWS;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (LOAD_CYCLES + 80) + 600;

	// the first sum follows the start by the scan, the bank read and the adder register.
	localparam int START_TO_SUM = 5;

	logic clk;
	logic i_reset;
	logic i_start;
	logic i_wen0;
	logic i_wen1;
	stream_pkg::feat_t i_ddr;
	stream_pkg::feat_t i_pool;
	stream_pkg::feat_t i_eltwise;
	logic i_eltwise_sel;
	stream_pkg::addr_t i_waddr;
	stream_pkg::feat_t o_sum;
	logic o_sum_valid;
	logic o_sum_last;

	// shadow copies of both banks.
	stream_pkg::feat_t shadow0 [0:stream_pkg::DEPTH-1];
	stream_pkg::feat_t shadow1 [0:stream_pkg::DEPTH-1];
	logic [31:0] lfsr_state = 32'd73749;
	int cycle_count = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_failed = 0;
	int tests_run = 0;

	feature_stream_top u_feature_stream_top (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.i_wen0(i_wen0),
		.i_wen1(i_wen1),
		.i_ddr(i_ddr),
		.i_pool(i_pool),
		.i_eltwise(i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.i_waddr(i_waddr),
		.o_sum(o_sum),
		.o_sum_valid(o_sum_valid),
		.o_sum_last(o_sum_last)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and random source.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic next_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out_bit;
	endfunction

	function automatic int rand_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(next_bit());
		end
		return value;
	endfunction

	function automatic int small_value();
		return rand_bits(11) - 1024;
	endfunction

	// k-th address of the row walk.
	function automatic int walk_addr(input int k);
		return (k / stream_pkg::LINE_LEN) * stream_pkg::ROW_STRIDE + (k % stream_pkg::LINE_LEN);
	endfunction

	function automatic int clamp_sum(input int a, input int b);
		int s;
		s = a + b;
		if (s > 32767) begin
			return 32767;
		end else if (s < -32768) begin
			return -32768;
		end
		return s;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// drivers and collector.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic write_word(input int addr, input logic en0, input logic en1,
		input logic sel, input int ddr, input int pool, input int elt);
		@(negedge clk);
		i_waddr = stream_pkg::addr_t'(addr);
		i_wen0 = en0;
		i_wen1 = en1;
		i_eltwise_sel = sel;
		i_ddr = stream_pkg::feat_t'(ddr);
		i_pool = stream_pkg::feat_t'(pool);
		i_eltwise = stream_pkg::feat_t'(elt);
		if (en0) begin
			shadow0[addr] = stream_pkg::feat_t'(ddr);
		end
		if (en1) begin
			shadow1[addr] = sel ? stream_pkg::feat_t'(elt) : stream_pkg::feat_t'(pool);
		end
	endtask

	task automatic end_writes();
		@(negedge clk);
		i_wen0 = 1'b0;
		i_wen1 = 1'b0;
		i_eltwise_sel = 1'b0;
	endtask

	// starts a scan on the first cycle and optionally once more at extra_start.
	task automatic collect_stream(input string name, input int extra_start, input int n_streams);
		int words;
		int first_cycle;
		int start_cycle;
		int k;
		int expected;
		words = 0;
		first_cycle = 0;
		for (int c = 0; c < n_streams * 70 + 30; c++) begin
			@(negedge clk);
			if (o_sum_valid) begin
				k = words % WALK_LEN;
				expected = clamp_sum(shadow0[walk_addr(k)], shadow1[walk_addr(k)]);
				if (k == 0) begin
					first_cycle = c;
					start_cycle = (words == 0) ? 0 : extra_start;
					assert (c == start_cycle + START_TO_SUM) else begin
						$display("FAIL %s first word cycle: expected %0d actual %0d", name,
							start_cycle + START_TO_SUM, c);
						test_errors++;
					end
				end
				assert (c == first_cycle + k) else begin
					$display("%s: word %0d came after a gap in the valid stream", name, words);
					test_errors++;
				end
				assert (int'(o_sum) == expected) else begin
					$display("FAIL %s word %0d: expected %0d actual %0d", name, words,
						expected, int'(o_sum));
					test_errors++;
				end
				assert (o_sum_last == (k == WALK_LEN - 1)) else begin
					$display("FAIL %s word %0d last flag: expected %0d actual %0d", name,
						words, int'(k == WALK_LEN - 1), int'(o_sum_last));
					test_errors++;
				end
				words++;
			end else begin
				assert (!o_sum_last) else begin
					$display("%s: last flag was high on a cycle without valid", name);
					test_errors++;
				end
			end
			i_start = (c == 0 || c == extra_start);
		end
		assert (words == n_streams * WALK_LEN) else begin
			$display("FAIL %s word count: expected %0d actual %0d", name,
				n_streams * WALK_LEN, words);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_idle();
		repeat (20) begin
			@(negedge clk);
			assert (!o_sum_valid && !o_sum_last) else begin
				$display("idle: output flags went high with no scan started");
				test_errors++;
			end
		end
		finish_test("idle");
	endtask

	task automatic test_pool_stream();
		for (int a = 0; a < LOAD_CYCLES; a++) begin
			write_word(a, 1'b1, 1'b1, 1'b0, small_value(), small_value(), small_value());
		end
		end_writes();
		collect_stream("pool", -1, 1);
		finish_test("pool");
	endtask

	// bank 0 keeps its contents, pool data differs from the element-wise data.
	task automatic test_eltwise_stream();
		for (int a = 0; a < LOAD_CYCLES; a++) begin
			write_word(a, 1'b0, 1'b1, 1'b1, 0, small_value(), small_value());
		end
		end_writes();
		collect_stream("eltwise", -1, 1);
		finish_test("eltwise");
	endtask

	task automatic test_saturation();
		for (int a = 0; a < LOAD_CYCLES; a++) begin
			if (a % 2 == 1) begin
				write_word(a, 1'b1, 1'b1, 1'b0, 32767 - rand_bits(6), rand_bits(8), 0);
			end else begin
				write_word(a, 1'b1, 1'b1, 1'b0, -32768 + rand_bits(6), -rand_bits(8), 0);
			end
		end
		end_writes();
		collect_stream("saturation", -1, 1);
		finish_test("saturation");
	endtask

	// a start mid-scan is ignored, one right after the scan ends is taken.
	task automatic test_restart();
		collect_stream("restart mid", 20, 1);
		collect_stream("restart back", WALK_LEN + 1, 2);
		finish_test("restart");
	endtask

	initial begin
		i_reset = 1'b1;
		i_start = 1'b0;
		i_wen0 = 1'b0;
		i_wen1 = 1'b0;
		i_ddr = '0;
		i_pool = '0;
		i_eltwise = '0;
		i_eltwise_sel = 1'b0;
		i_waddr = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		i_reset = 1'b0;
		test_idle();
		test_pool_stream();
		test_eltwise_stream();
		test_saturation();
		test_restart();
		$display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
			total_errors);
		if (tests_failed == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== stream_buffer.f ====
verilog/stream_pkg.sv
verilog/feature_ram.sv
verilog/scan_address_gen.sv
verilog/stream_buffer.sv
verilog/residual_adder.sv
verilog/feature_stream_top.sv
tests/tb_feature_stream.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_feature_stream
FILELIST = stream_buffer.f

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
